// File: logic/ycr_router_config.svh
`ifndef YCR_ROUTER_CONFIG_SVH
`define YCR_ROUTER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Memory bus widths
////////////////////////////////////////////////////////////////////////////

// Byte address toward the shared memory
`define YCR_IMEM_AWIDTH 32
// Read and write data
`define YCR_IMEM_DWIDTH 32
// Burst length field width
`define YCR_IMEM_BSIZE 3

////////////////////////////////////////////////////////////////////////////
// Router sizing
////////////////////////////////////////////////////////////////////////////

`define YCR_TID_WIDTH 3
// Four cores times imem and dmem
`define YCR_ROUTER_PORTS 8

`endif

// File: logic/ycr_mem_pkg.sv
`include "ycr_router_config.svh"

package ycr_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory protocol encodings
    ////////////////////////////////////////////////////////////////////////////

    // Response code returned with every memory cycle
    typedef enum logic [1:0] {
        RESP_NOTRDY  = 2'b00,
        RESP_RDY_OK  = 2'b01,
        RESP_RDY_ER  = 2'b10,
        // Final beat of a burst
        RESP_RDY_LOK = 2'b11
    } mem_resp_e;

    // Access direction
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Target id carried by each requester
    typedef logic [`YCR_TID_WIDTH-1:0] tid_t;

    ////////////////////////////////////////////////////////////////////////////
    // Beat structs
    ////////////////////////////////////////////////////////////////////////////

    // Command fields toward memory
    typedef struct packed {
        logic                        req;
        mem_cmd_e                    cmd;
        logic [1:0]                  width;
        logic [`YCR_IMEM_AWIDTH-1:0] addr;
        logic [`YCR_IMEM_BSIZE-1:0]  bl;
        logic [`YCR_IMEM_DWIDTH-1:0] wdata;
    } mem_cmd_t;

    // Requester side command with its target id
    typedef struct packed {
        mem_cmd_t cmd;
        tid_t     tid;
    } port_req_t;

    // Response seen by one requester
    typedef struct packed {
        logic                        req_ack;
        logic                        lack;
        logic [`YCR_IMEM_DWIDTH-1:0] rdata;
        mem_resp_e                   resp;
    } port_rsp_t;

    // Response from the memory target
    typedef struct packed {
        logic                        req_ack;
        logic [`YCR_IMEM_DWIDTH-1:0] rdata;
        mem_resp_e                   resp;
    } mem_rsp_t;

endpackage : ycr_mem_pkg

// File: logic/ycr_router_pkg.sv
`include "ycr_router_config.svh"

package ycr_router_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Router internal types
    ////////////////////////////////////////////////////////////////////////////

    // Requester index
    // Even entries are imem and odd entries are dmem of core idx/2
    typedef logic [$clog2(`YCR_ROUTER_PORTS)-1:0] port_idx_t;

    // Locked grant
    // Valid low means the memory side is idle
    typedef struct packed {
        logic      valid;
        port_idx_t idx;
    } grant_t;

    // One bit per requester
    typedef logic [`YCR_ROUTER_PORTS-1:0] port_vec_t;

endpackage : ycr_router_pkg

// File: logic/ycr_arb.sv
`timescale 1ns/1ns

`include "ycr_router_config.svh"

module ycr_arb
    import ycr_router_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Requests already filtered on target id
    input  port_vec_t req,
    // Last response beat of the granted transaction
    input  logic      lack,
    output grant_t    grant
);

    ////////////////////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////////////////////

    // Locked grant register
    grant_t    grant_q;
    // Last granted index
    port_idx_t ptr_q;

    // Round-robin pick
    port_idx_t next_idx;
    logic      next_found;

    ////////////////////////////////////////////////////////////////////////////
    // Next requester after the pointer
    ////////////////////////////////////////////////////////////////////////////

    // Scan starts one past the pointer and wraps
    // Pointer itself is checked last
    always_comb begin
        next_idx   = ptr_q;
        next_found = 1'b0;
        for (int off = 1; off <= `YCR_ROUTER_PORTS; off++) begin
            if (!next_found && req[(int'(ptr_q) + off) % `YCR_ROUTER_PORTS]) begin
                next_idx   = port_idx_t'((int'(ptr_q) + off) % `YCR_ROUTER_PORTS);
                next_found = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant lock
    ////////////////////////////////////////////////////////////////////////////

    // Hold while valid and release on lack
    // Idle cycle follows every release before the next pick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= '0;
            // Port 0 wins first after reset
            ptr_q   <= port_idx_t'(`YCR_ROUTER_PORTS - 1);
        end else if (grant_q.valid) begin
            if (lack) begin
                grant_q <= '0;
            end
        end else if (next_found) begin
            grant_q <= '{valid: 1'b1, idx: next_idx};
            ptr_q   <= next_idx;
        end
    end

    assign grant = grant_q;

endmodule : ycr_arb

// File: logic/ycr_req_mux.sv
`timescale 1ns/1ns

`include "ycr_router_config.svh"

module ycr_req_mux
    import ycr_mem_pkg::*;
    import ycr_router_pkg::*;
(
    // All requester commands
    input  port_req_t [`YCR_ROUTER_PORTS-1:0] port_req,
    // Own id of this memory target
    input  tid_t                              target_id,
    input  grant_t                            grant,
    // Requests addressed to this target
    output port_vec_t                         req_vec,
    // Command toward memory
    output mem_cmd_t                          mem_cmd
);

    ////////////////////////////////////////////////////////////////////////////
    // Target id filter
    ////////////////////////////////////////////////////////////////////////////

    // Only matching ids reach the arbiter
    always_comb begin
        for (int i = 0; i < `YCR_ROUTER_PORTS; i++) begin
            req_vec[i] = port_req[i].cmd.req && (port_req[i].tid == target_id);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command select
    ////////////////////////////////////////////////////////////////////////////

    // Granted fields go out as they are
    // Req is the filtered one so a foreign id never shows up
    always_comb begin
        mem_cmd = '0;
        if (grant.valid) begin
            mem_cmd     = port_req[grant.idx].cmd;
            mem_cmd.req = req_vec[grant.idx];
        end
    end

endmodule : ycr_req_mux

// File: logic/ycr_rsp_demux.sv
`timescale 1ns/1ns

`include "ycr_router_config.svh"

module ycr_rsp_demux
    import ycr_mem_pkg::*;
    import ycr_router_pkg::*;
(
    // Response from the memory target
    input  mem_rsp_t                          mem_rsp,
    input  grant_t                            grant,
    // Per requester responses
    output port_rsp_t [`YCR_ROUTER_PORTS-1:0] port_rsp,
    // End of transaction toward the arbiter
    output logic                              lack
);

    ////////////////////////////////////////////////////////////////////////////
    // Last response decode
    ////////////////////////////////////////////////////////////////////////////

    assign lack = (mem_rsp.resp == RESP_RDY_LOK);

    ////////////////////////////////////////////////////////////////////////////
    // Response routing
    ////////////////////////////////////////////////////////////////////////////

    // Granted port gets the memory response
    // Every other port stays at zero
    always_comb begin
        port_rsp = '0;
        if (grant.valid) begin
            port_rsp[grant.idx].req_ack = mem_rsp.req_ack;
            port_rsp[grant.idx].lack    = lack;
            port_rsp[grant.idx].rdata   = mem_rsp.rdata;
            // Cores expect last beat on lack only
            // Bit 1 of the code is cleared so LOK looks like OK
            port_rsp[grant.idx].resp    = mem_resp_e'({1'b0, mem_rsp.resp[0]});
        end
    end

endmodule : ycr_rsp_demux

// File: logic/ycr_router_top.sv
`timescale 1ns/1ns

`include "ycr_router_config.svh"

module ycr_router_top
    import ycr_mem_pkg::*;
    import ycr_router_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    // Static id of this memory target
    input  tid_t                              target_id,
    // Requester side, index is 2*core plus 1 for dmem
    input  port_req_t [`YCR_ROUTER_PORTS-1:0] port_req,
    output port_rsp_t [`YCR_ROUTER_PORTS-1:0] port_rsp,
    // Memory side
    output mem_cmd_t                          mem_cmd,
    input  mem_rsp_t                          mem_rsp
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////////////////////

    port_vec_t req_vec;
    grant_t    grant;
    logic      lack;

    ////////////////////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////////////////////

    ycr_req_mux u_req_mux (
        .port_req  (port_req),
        .target_id (target_id),
        .grant     (grant),
        .req_vec   (req_vec),
        .mem_cmd   (mem_cmd)
    );

    // Grant locked until the last response
    ycr_arb u_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_vec),
        .lack  (lack),
        .grant (grant)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////////////////////

    ycr_rsp_demux u_rsp_demux (
        .mem_rsp  (mem_rsp),
        .grant    (grant),
        .port_rsp (port_rsp),
        .lack     (lack)
    );

endmodule : ycr_router_top

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    // Clock period in ns
    parameter int PERIOD       = 4,
    // Cycles with rst_n held low
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    // Free running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release lands on a falling edge
    initial begin
        rst_n = 1'b0;
        #(PERIOD * RESET_CYCLES);
        rst_n = 1'b1;
    end

endmodule : tb_clk_gen

// File: test/ycr_router_assert.sv
`timescale 1ns/1ns

`include "ycr_router_config.svh"

module ycr_router_assert
    import ycr_mem_pkg::*;
    import ycr_router_pkg::*;
(
    input logic                              clk,
    input logic                              rst_n,
    // Locked grant inside the router
    input grant_t                            grant,
    // Last response decode
    input logic                              lack,
    input mem_cmd_t                          mem_cmd,
    input port_rsp_t [`YCR_ROUTER_PORTS-1:0] port_rsp
);

    // Acknowledge bits of all ports
    port_vec_t ack_vec;

    // Failed property count
    int unsigned fail_cnt = 0;

    always_comb begin
        for (int i = 0; i < `YCR_ROUTER_PORTS; i++) begin
            ack_vec[i] = port_rsp[i].req_ack;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant and protocol properties
    ////////////////////////////////////////////////////////////////////////////

    // Locked until the last beat
    grant_held : assert property (@(posedge clk) disable iff (!rst_n)
        grant.valid && !lack |=> grant == $past(grant))
        else begin
            $error("Grant changed before the last response of its transaction");
            fail_cnt = fail_cnt + 1;
        end

    // Acknowledge reaches one port only
    one_ack : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ack_vec))
        else begin
            $error("More than one port sees req_ack in the same cycle");
            fail_cnt = fail_cnt + 1;
        end

    // Idle gap between two transactions
    gap_after_lack : assert property (@(posedge clk) disable iff (!rst_n)
        grant.valid && lack |=> !mem_cmd.req)
        else begin
            $error("Memory req did not drop for a cycle after the last response");
            fail_cnt = fail_cnt + 1;
        end

endmodule : ycr_router_assert

bind ycr_router_top ycr_router_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .grant    (grant),
    .lack     (lack),
    .mem_cmd  (mem_cmd),
    .port_rsp (port_rsp)
);

// File: test/ycr_router_tb.sv
`timescale 1ns/1ns

`include "ycr_router_config.svh"

module ycr_router_tb
    import ycr_mem_pkg::*;
    import ycr_router_pkg::*;
();

    localparam int PORTS          = `YCR_ROUTER_PORTS;
    localparam int RR_ROUNDS      = 3;
    localparam int RAND_PER_PORT  = 2;
    localparam int FOREIGN_CYCLES = 24;
    // Single port pass, foreign test, round-robin and random traffic
    localparam int TOTAL_TXN      = PORTS + 4 + PORTS * RR_ROUNDS + PORTS * RAND_PER_PORT;
    localparam int CYCLE_LIMIT    = 40 * TOTAL_TXN + 100;

    logic                  clk;
    logic                  rst_n;
    tid_t                  target_id;
    port_req_t [PORTS-1:0] port_req;
    port_rsp_t [PORTS-1:0] port_rsp;
    mem_cmd_t              mem_cmd;
    mem_rsp_t              mem_rsp;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;

    // Reference state of the checker
    logic      exp_valid;
    port_idx_t exp_idx;
    port_idx_t exp_last;
    int        beat;
    int        grant_cnt [PORTS];
    // Port indices seen on the memory side, decoded from addr
    port_idx_t grant_log [$];
    logic      prev_req;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ycr_router_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .target_id (target_id),
        .port_req  (port_req),
        .port_rsp  (port_rsp),
        .mem_cmd   (mem_cmd),
        .mem_rsp   (mem_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference and compare
    ////////////////////////////////////////////////////////////////////////////

    // First requesting index after the last grant, cyclic
    function automatic port_idx_t next_grant(input port_vec_t req, input port_idx_t last);
        port_idx_t cand;
        cand = last;
        for (int n = 0; n < PORTS; n++) begin
            cand = cand + 1'b1;
            if (req[cand]) begin
                return cand;
            end
        end
        return last;
    endfunction

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Values before the edge, grant decision taken at the edge
    always @(posedge clk) begin : compare
        port_vec_t req_now;
        mem_cmd_t  exp_cmd;
        port_rsp_t exp_rsp;
        if (!rst_n) begin
            exp_valid = 1'b0;
            exp_last  = port_idx_t'(PORTS - 1);
            prev_req  = 1'b0;
        end else begin
            // Only matching ids take part
            for (int i = 0; i < PORTS; i++) begin
                req_now[i] = port_req[i].cmd.req && (port_req[i].tid == target_id);
            end
            exp_cmd = '0;
            if (exp_valid) begin
                exp_cmd = port_req[exp_idx].cmd;
            end
            check_eq(mem_cmd, exp_cmd, "memory command");
            for (int i = 0; i < PORTS; i++) begin
                exp_rsp = '0;
                if (exp_valid && port_idx_t'(i) == exp_idx) begin
                    exp_rsp.req_ack = mem_rsp.req_ack;
                    exp_rsp.lack    = (mem_rsp.resp == RESP_RDY_LOK);
                    exp_rsp.rdata   = mem_rsp.rdata;
                    // Bit 1 of the code never reaches a core
                    exp_rsp.resp    = mem_resp_e'(mem_rsp.resp & 2'b01);
                end
                check_eq(port_rsp[i], exp_rsp, $sformatf("response of port %0d", i));
            end
            if (mem_cmd.req && !prev_req) begin
                grant_log.push_back(port_idx_t'(mem_cmd.addr[31:28]));
            end
            prev_req = mem_cmd.req;
            if (exp_valid) begin
                if (mem_rsp.resp == RESP_RDY_OK || mem_rsp.resp == RESP_RDY_LOK) begin
                    check_eq(port_rsp[exp_idx].rdata, port_req[exp_idx].cmd.addr ^ 32'(beat),
                             "beat data");
                    if (mem_rsp.resp == RESP_RDY_LOK) begin
                        check_eq(beat, port_req[exp_idx].cmd.bl, "beats before last");
                        exp_valid = 1'b0;
                    end
                    beat++;
                end
            end else if (|req_now) begin
                exp_idx   = next_grant(req_now, exp_last);
                exp_last  = exp_idx;
                exp_valid = 1'b1;
                beat      = 0;
                grant_cnt[exp_idx]++;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: transactions did not complete within %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory model and requesters
    ////////////////////////////////////////////////////////////////////////////

    // Ack after 0..3 cycles, then bl+1 beats with random gaps
    task automatic memory_model();
        mem_cmd_t    c;
        int unsigned delay;
        forever begin
            @(negedge clk);
            mem_rsp = '0;
            if (rst_n && mem_cmd.req) begin
                c     = mem_cmd;
                delay = $urandom_range(0, 3);
                repeat (delay) @(negedge clk);
                mem_rsp.req_ack = 1'b1;
                for (int b = 0; b <= int'(c.bl); b++) begin
                    @(negedge clk);
                    mem_rsp = '0;
                    if ($urandom_range(0, 1) == 1) begin
                        @(negedge clk);
                    end
                    mem_rsp.rdata = c.addr ^ 32'(b);
                    mem_rsp.resp  = (b == int'(c.bl)) ? RESP_RDY_LOK : RESP_RDY_OK;
                end
            end
        end
    endtask

    // Called on a falling edge, holds the request until lack
    task automatic run_txn(input int p);
        port_req_t r;
        r.cmd.req   = 1'b1;
        r.cmd.cmd   = mem_cmd_e'($urandom_range(0, 1));
        r.cmd.width = 2'($urandom_range(0, 3));
        // Top nibble names the port
        r.cmd.addr  = {4'(p), 28'($urandom)};
        r.cmd.bl    = 3'($urandom_range(0, 7));
        r.cmd.wdata = $urandom;
        r.tid       = target_id;
        port_req[p] = r;
        @(posedge clk);
        while (!port_rsp[p].lack) begin
            @(posedge clk);
        end
        @(negedge clk);
        port_req[p] = '0;
    endtask

    // Request with a wrong target id, never served
    task automatic hold_foreign(input int p, input int n);
        port_req_t r;
        r           = '0;
        r.cmd.req   = 1'b1;
        r.cmd.addr  = {4'(p), 28'($urandom)};
        r.tid       = target_id ^ 3'($urandom_range(1, 7));
        port_req[p] = r;
        repeat (n) @(negedge clk);
        port_req[p] = '0;
    endtask

    task automatic port_sequence(input int p, input bit gaps, input int rounds);
        for (int k = 0; k < rounds; k++) begin
            if (gaps) begin
                repeat ($urandom_range(0, 5)) @(negedge clk);
            end
            run_txn(p);
        end
    endtask

    // All ports in parallel
    task automatic all_ports(input bit gaps, input int rounds);
        fork
            begin
                for (int p = 0; p < PORTS; p++) begin
                    fork
                        automatic int q = p;
                        port_sequence(q, gaps, rounds);
                    join_none
                end
                wait fork;
            end
        join
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        port_idx_t after;
        target_id = 3'd5;
        port_req  = '0;
        mem_rsp   = '0;
        void'($urandom(32'hb64226f8));
        fork
            memory_model();
        join_none
        wait (rst_n === 1'b1);
        @(negedge clk);

        // Idle after reset, checker expects zeros
        repeat (10) @(negedge clk);

        // One port at a time
        for (int p = 0; p < PORTS; p++) begin
            run_txn(p);
            repeat (2) @(negedge clk);
        end

        // Odd ports carry a foreign id
        fork
            hold_foreign(1, FOREIGN_CYCLES);
            hold_foreign(3, FOREIGN_CYCLES);
            hold_foreign(5, FOREIGN_CYCLES);
            hold_foreign(7, FOREIGN_CYCLES);
            begin
                run_txn(0);
                run_txn(2);
            end
            begin
                run_txn(4);
                run_txn(6);
            end
        join
        repeat (2) @(negedge clk);

        // Continuous requests on every port
        grant_log.delete();
        foreach (grant_cnt[i]) begin
            grant_cnt[i] = 0;
        end
        all_ports(1'b0, RR_ROUNDS);
        for (int p = 0; p < PORTS; p++) begin
            check_eq(grant_cnt[p], RR_ROUNDS, $sformatf("grants of port %0d", p));
        end
        check_eq(grant_log.size(), PORTS * RR_ROUNDS, "grants in round-robin test");
        // Strictly cyclic order while everybody waits
        for (int k = 1; k < grant_log.size(); k++) begin
            after = grant_log[k-1] + 1'b1;
            check_eq(grant_log[k], after, "round-robin order");
        end
        repeat (2) @(negedge clk);

        // Random gaps and random memory delay
        all_ports(1'b1, RAND_PER_PORT);
        repeat (5) @(negedge clk);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d, cycles: %0d",
                 checks, errors, dut0.u_assert.fail_cnt, cycles);
        if (errors == 0 && dut0.u_assert.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : ycr_router_tb

// File: ycr_router_top.f
+incdir+logic
logic/ycr_mem_pkg.sv
logic/ycr_router_pkg.sv
logic/ycr_arb.sv
logic/ycr_req_mux.sv
logic/ycr_rsp_demux.sv
logic/ycr_router_top.sv
test/tb_clk_gen.sv
test/ycr_router_assert.sv
test/ycr_router_tb.sv
